// ==== project.f ====
+incdir+.
issue_pkg.sv
issue_scoreboard.sv
issue_pair_ctrl.sv
issue_xarith_port.sv
issue_xlogic_port.sv
warp_issue.sv
issue_tb.sv

// ==== issue_tb_checks.svh ====
`ifndef ISSUE_TB_CHECKS_SVH
`define ISSUE_TB_CHECKS_SVH

// compare tasks, one per kind of result, each naming the running test

task automatic xarith_cmd_ok(input string what, input issue_pkg::xarith_cmd_t exp,
                             input issue_pkg::xarith_cmd_t act);
    if (act !== exp) begin
        value_errors++;
        $display("** Error [%s] %s at %0t: expected %h, actual %h",
                 test_name, what, $time, exp, act);
    end
endtask

task automatic xlogic_cmd_ok(input string what, input issue_pkg::xlogic_cmd_t exp,
                             input issue_pkg::xlogic_cmd_t act);
    if (act !== exp) begin
        value_errors++;
        $display("** Error [%s] %s at %0t: expected %h, actual %h",
                 test_name, what, $time, exp, act);
    end
endtask

task automatic addr_ok(input string what, input issue_pkg::reg_addr_t exp,
                       input issue_pkg::reg_addr_t act);
    if (act !== exp) begin
        value_errors++;
        $display("** Error [%s] %s at %0t: expected x%0d, actual x%0d",
                 test_name, what, $time, exp, act);
    end
endtask

task automatic strobe_ok(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        value_errors++;
        $display("** Error [%s] %s at %0t: expected %b, actual %b",
                 test_name, what, $time, exp, act);
    end
endtask

// failures that are not a wrong value, such as a stall that never ends
task automatic other_failure(input string msg);
    other_errors++;
    $display("Error [%s] at %0t: %s", test_name, $time, msg);
endtask

task automatic report_counts();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
endtask

`endif

// ==== issue_tb.sv ====
`timescale 1ns/1ps

module issue_tb;

    typedef struct packed {
        logic                   send0;
        logic                   send1;
        issue_pkg::reg_mask_t   res_next;
        issue_pkg::pair_state_e state_next;
    } pred_t;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     i_valid;
    issue_pkg::issue_bundle_t i_bundle0;
    issue_pkg::issue_bundle_t i_bundle1;
    logic                     o_input_ready;
    issue_pkg::reg_addr_t     o_rs1_addr;
    issue_pkg::reg_addr_t     o_rs2_addr;
    issue_pkg::reg_addr_t     o_rs3_addr;
    issue_pkg::reg_addr_t     o_rs4_addr;
    issue_pkg::xarith_cmd_t   o_xarith_cmd;
    logic                     o_xarith_valid;
    logic                     i_xarith_ready;
    issue_pkg::xlogic_cmd_t   o_xlogic_cmd;
    logic                     o_xlogic_valid;
    logic                     i_xlogic_ready;
    issue_pkg::reg_mask_t     i_retire0;
    issue_pkg::reg_mask_t     i_retire1;

    int                     value_errors = 0;
    int                     other_errors = 0;
    string                  test_name = "reset";
    logic [31:0]            lcg_state = 32'hdd2e_fad3;
    // model of the reservation and the pair state after the coming edge
    issue_pkg::reg_mask_t   model_res;
    issue_pkg::pair_state_e model_state;
    logic                   exp_xa_valid;
    logic                   exp_xl_valid;
    issue_pkg::xarith_cmd_t exp_xa_cmd;
    issue_pkg::xlogic_cmd_t exp_xl_cmd;
    issue_pkg::reg_addr_t   exp_addr [4];

    `include "issue_tb_checks.svh"

    warp_issue dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random control fields and immediate, chosen registers and unit
    function automatic issue_pkg::issue_bundle_t make_bundle(input logic [3:0] pipe,
            input issue_pkg::reg_addr_t rd, input issue_pkg::reg_addr_t rs1,
            input issue_pkg::reg_addr_t rs2, input logic op2_sel);
        logic [95:0]              bits;
        issue_pkg::issue_bundle_t b;
        bits = {next_random(), next_random(), next_random()};
        b = bits[67:0];
        b.pipeline = issue_pkg::pipe_e'(pipe);
        b.rd = rd;
        b.rs1 = rs1;
        b.rs2 = rs2;
        b.op2_sel = op2_sel;
        return b;
    endfunction

    function automatic logic unit_ready(input issue_pkg::pipe_e pipe, input logic xa,
                                        input logic xl);
        return (pipe == issue_pkg::PIPE_XARITH && xa) || (pipe == issue_pkg::PIPE_XLOGIC && xl);
    endfunction

    // expected transmits and next model state for one cycle
    function automatic pred_t predict(input issue_pkg::reg_mask_t res,
            input issue_pkg::pair_state_e st, input logic valid,
            input issue_pkg::issue_bundle_t b0, input issue_pkg::issue_bundle_t b1,
            input logic xa, input logic xl, input issue_pkg::reg_mask_t retire);
        pred_t                p;
        logic                 free0;
        logic                 free1;
        logic                 together;
        issue_pkg::reg_mask_t set;
        free0 = !res[b0.rd] && !res[b0.rs1] && (b0.op2_sel || !res[b0.rs2]);
        free1 = !res[b1.rd] && !res[b1.rs1] && (b1.op2_sel || !res[b1.rs2]);
        p.send0 = valid && st == issue_pkg::PAIR_BOTH && free0 && unit_ready(b0.pipeline, xa, xl);
        together = p.send0 && b0.rd != b1.rd && b0.pipeline != b1.pipeline;
        p.send1 = valid && free1 && unit_ready(b1.pipeline, xa, xl)
                  && (st == issue_pkg::PAIR_SECOND || together);
        set = '0;
        if (p.send0) begin
            set[b0.rd] = 1'b1;
        end
        if (p.send1) begin
            set[b1.rd] = 1'b1;
        end
        set[0] = 1'b0;
        p.res_next = (res & ~retire) | set;
        if (p.send1) begin
            p.state_next = issue_pkg::PAIR_BOTH;
        end else begin
            p.state_next = p.send0 ? issue_pkg::PAIR_SECOND : st;
        end
        return p;
    endfunction

    // the command a unit should show in the cycle after a launch
    task automatic expect_launch(input issue_pkg::issue_bundle_t b, input logic sel1);
        if (b.pipeline == issue_pkg::PIPE_XARITH) begin
            exp_xa_valid = 1'b1;
            exp_xa_cmd.banksel = sel1;
            exp_xa_cmd.op2_sel = b.op2_sel;
            exp_xa_cmd.imm = {{32{b.imm[31]}}, b.imm};
            exp_xa_cmd.ctrl = b.xarith;
            exp_xa_cmd.rd = b.rd;
        end else begin
            exp_xl_valid = 1'b1;
            exp_xl_cmd.banksel = sel1;
            exp_xl_cmd.op2_sel = b.op2_sel;
            exp_xl_cmd.imm = {{32{b.imm[31]}}, b.imm};
            exp_xl_cmd.ctrl = b.xlogic;
            exp_xl_cmd.rd = b.rd;
        end
    endtask

    // samples mid-way to the rising edge, where inputs and outputs are settled
    initial begin : compare_proc
        pred_t p;
        forever begin
            @(negedge i_clk);
            #10;
            if (!i_rst_n) begin
                model_res = '0;
                model_state = issue_pkg::PAIR_BOTH;
                exp_xa_valid = 1'b0;
                exp_xl_valid = 1'b0;
                exp_addr = '{default: '0};
            end
            strobe_ok("xarith valid", exp_xa_valid, o_xarith_valid);
            strobe_ok("xlogic valid", exp_xl_valid, o_xlogic_valid);
            if (exp_xa_valid) begin
                xarith_cmd_ok("xarith cmd", exp_xa_cmd, o_xarith_cmd);
            end
            if (exp_xl_valid) begin
                xlogic_cmd_ok("xlogic cmd", exp_xl_cmd, o_xlogic_cmd);
            end
            addr_ok("rs1 addr", exp_addr[0], o_rs1_addr);
            addr_ok("rs2 addr", exp_addr[1], o_rs2_addr);
            addr_ok("rs3 addr", exp_addr[2], o_rs3_addr);
            addr_ok("rs4 addr", exp_addr[3], o_rs4_addr);
            if (!i_rst_n) begin
                continue;
            end
            p = predict(model_res, model_state, i_valid, i_bundle0, i_bundle1,
                        i_xarith_ready, i_xlogic_ready, i_retire0 | i_retire1);
            strobe_ok("input ready", p.send1, o_input_ready);
            exp_xa_valid = 1'b0;
            exp_xl_valid = 1'b0;
            if (p.send0) begin
                expect_launch(i_bundle0, 1'b0);
            end
            if (p.send1) begin
                expect_launch(i_bundle1, 1'b1);
            end
            exp_addr = '{i_bundle0.rs1, i_bundle0.rs2, i_bundle1.rs1, i_bundle1.rs2};
            model_res = p.res_next;
            model_state = p.state_next;
        end
    end

    // the stimulus tasks start and end on a falling edge
    task automatic offer_pair(input issue_pkg::issue_bundle_t b0,
                              input issue_pkg::issue_bundle_t b1);
        i_valid = 1'b1;
        i_bundle0 = b0;
        i_bundle1 = b1;
    endtask

    task automatic wait_consumed(input int limit);
        int cycles;
        cycles = 0;
        #10;
        while (!o_input_ready && cycles < limit) begin
            @(negedge i_clk);
            #10;
            cycles++;
        end
        if (!o_input_ready) begin
            other_failure("the pair was not consumed before the timeout");
        end
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    task automatic expect_no_consume(input int cycles);
        repeat (cycles) begin
            #10;
            if (o_input_ready) begin
                other_failure("the pair was consumed while it should have stalled");
            end
            @(negedge i_clk);
        end
    endtask

    task automatic pulse_retire(input issue_pkg::reg_mask_t m0, input issue_pkg::reg_mask_t m1);
        i_retire0 = m0;
        i_retire1 = m1;
        @(negedge i_clk);
        i_retire0 = '0;
        i_retire1 = '0;
    endtask

    initial begin : stimulus_proc
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_bundle0 = '0;
        i_bundle1 = '0;
        i_xarith_ready = 1'b1;
        i_xlogic_ready = 1'b1;
        i_retire0 = '0;
        i_retire1 = '0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        test_name = "independent_pair";
        offer_pair(make_bundle(4'd1, 5'd3, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd2, 5'd4, 5'd6, 5'd7, 1'b1));
        wait_consumed(4);
        pulse_retire(32'h1 << 3, 32'h1 << 4);

        test_name = "raw_stall";
        offer_pair(make_bundle(4'd1, 5'd8, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd2, 5'd9, 5'd3, 5'd4, 1'b0));
        wait_consumed(4);
        offer_pair(make_bundle(4'd1, 5'd10, 5'd8, 5'd0, 1'b0),
                   make_bundle(4'd2, 5'd11, 5'd9, 5'd2, 1'b0));
        expect_no_consume(5);
        pulse_retire(32'h1 << 8, 32'h1 << 9);
        wait_consumed(4);
        pulse_retire((32'h1 << 10) | (32'h1 << 11), '0);

        test_name = "in_pair_waw";
        offer_pair(make_bundle(4'd1, 5'd12, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd2, 5'd12, 5'd3, 5'd4, 1'b0));
        expect_no_consume(4);
        pulse_retire(32'h1 << 12, '0);
        wait_consumed(4);
        pulse_retire('0, 32'h1 << 12);

        test_name = "same_unit_pair";
        offer_pair(make_bundle(4'd1, 5'd13, 5'd5, 5'd6, 1'b0),
                   make_bundle(4'd1, 5'd14, 5'd7, 5'd8, 1'b1));
        wait_consumed(4);
        pulse_retire(32'h1 << 13, 32'h1 << 14);

        test_name = "back_pressure";
        i_xlogic_ready = 1'b0;
        offer_pair(make_bundle(4'd1, 5'd15, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd2, 5'd16, 5'd3, 5'd4, 1'b0));
        expect_no_consume(4);
        i_xlogic_ready = 1'b1;
        wait_consumed(4);
        pulse_retire(32'h1 << 15, 32'h1 << 16);
        i_xlogic_ready = 1'b0;
        offer_pair(make_bundle(4'd2, 5'd17, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd1, 5'd18, 5'd3, 5'd4, 1'b0));
        expect_no_consume(3);
        i_xlogic_ready = 1'b1;
        wait_consumed(4);
        pulse_retire(32'h1 << 17, 32'h1 << 18);

        test_name = "register_masking";
        offer_pair(make_bundle(4'd1, 5'd0, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd2, 5'd0, 5'd3, 5'd4, 1'b0));
        wait_consumed(4);
        offer_pair(make_bundle(4'd1, 5'd20, 5'd0, 5'd0, 1'b0),
                   make_bundle(4'd2, 5'd21, 5'd0, 5'd5, 1'b0));
        wait_consumed(2);
        offer_pair(make_bundle(4'd1, 5'd22, 5'd1, 5'd20, 1'b1),
                   make_bundle(4'd2, 5'd23, 5'd2, 5'd21, 1'b1));
        wait_consumed(2);
        pulse_retire((32'h1 << 20) | (32'h1 << 21), (32'h1 << 22) | (32'h1 << 23));
        offer_pair(make_bundle(4'd9, 5'd24, 5'd1, 5'd2, 1'b0),
                   make_bundle(4'd1, 5'd25, 5'd3, 5'd4, 1'b0));
        expect_no_consume(8);
        i_valid = 1'b0;
        repeat (3) @(negedge i_clk);

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== warp_issue.sv ====
`timescale 1ns/1ps

module warp_issue (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  issue_pkg::issue_bundle_t  i_bundle0,
    input  issue_pkg::issue_bundle_t  i_bundle1,
    output logic                      o_input_ready,
    output issue_pkg::reg_addr_t      o_rs1_addr,
    output issue_pkg::reg_addr_t      o_rs2_addr,
    output issue_pkg::reg_addr_t      o_rs3_addr,
    output issue_pkg::reg_addr_t      o_rs4_addr,
    output issue_pkg::xarith_cmd_t    o_xarith_cmd,
    output logic                      o_xarith_valid,
    input  logic                      i_xarith_ready,
    output issue_pkg::xlogic_cmd_t    o_xlogic_cmd,
    output logic                      o_xlogic_valid,
    input  logic                      i_xlogic_ready,
    input  issue_pkg::reg_mask_t      i_retire0,
    input  issue_pkg::reg_mask_t      i_retire1
);

    logic clear0;
    logic clear1;
    logic send0;
    logic send1;
    logic xarith_go;
    logic xarith_sel1;
    logic xlogic_go;
    logic xlogic_sel1;

    issue_scoreboard scoreboard_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bundle0 (i_bundle0),
        .i_bundle1 (i_bundle1),
        .i_send0   (send0),
        .i_send1   (send1),
        .i_retire0 (i_retire0),
        .i_retire1 (i_retire1),
        .o_clear0  (clear0),
        .o_clear1  (clear1)
    );

    issue_pair_ctrl pair_ctrl_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .i_bundle0      (i_bundle0),
        .i_bundle1      (i_bundle1),
        .i_clear0       (clear0),
        .i_clear1       (clear1),
        .i_xarith_ready (i_xarith_ready),
        .i_xlogic_ready (i_xlogic_ready),
        .o_send0        (send0),
        .o_send1        (send1),
        .o_input_ready  (o_input_ready),
        .o_xarith_go    (xarith_go),
        .o_xarith_sel1  (xarith_sel1),
        .o_xlogic_go    (xlogic_go),
        .o_xlogic_sel1  (xlogic_sel1)
    );

    issue_xarith_port xarith_port_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bundle0 (i_bundle0),
        .i_bundle1 (i_bundle1),
        .i_go      (xarith_go),
        .i_sel1    (xarith_sel1),
        .o_cmd     (o_xarith_cmd),
        .o_valid   (o_xarith_valid)
    );

    issue_xlogic_port xlogic_port_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bundle0 (i_bundle0),
        .i_bundle1 (i_bundle1),
        .i_go      (xlogic_go),
        .i_sel1    (xlogic_sel1),
        .o_cmd     (o_xlogic_cmd),
        .o_valid   (o_xlogic_valid)
    );

    // the register file is read on the edge a bundle leaves, so its address
    // ports simply track both bundles one cycle behind
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rs1_addr <= '0;
            o_rs2_addr <= '0;
            o_rs3_addr <= '0;
            o_rs4_addr <= '0;
        end else begin
            o_rs1_addr <= i_bundle0.rs1;
            o_rs2_addr <= i_bundle0.rs2;
            o_rs3_addr <= i_bundle1.rs1;
            o_rs4_addr <= i_bundle1.rs2;
        end
    end

endmodule

// ==== issue_xlogic_port.sv ====
`timescale 1ns/1ps

module issue_xlogic_port (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  issue_pkg::issue_bundle_t  i_bundle0,
    input  issue_pkg::issue_bundle_t  i_bundle1,
    input  logic                      i_go,
    input  logic                      i_sel1,
    output issue_pkg::xlogic_cmd_t    o_cmd,
    output logic                      o_valid
);

    issue_pkg::issue_bundle_t bundle;
    issue_pkg::xlogic_cmd_t   cmd_d;

    // pick the bundle being launched into the logic unit
    assign bundle = i_sel1 ? i_bundle1 : i_bundle0;

    always_comb begin
        cmd_d.banksel = i_sel1;
        cmd_d.op2_sel = bundle.op2_sel;
        cmd_d.imm     = issue_pkg::sext_imm(bundle.imm);
        cmd_d.ctrl    = bundle.xlogic;
        cmd_d.rd      = bundle.rd;
    end

    always_ff @(posedge i_clk) begin
        if (i_go) begin
            o_cmd <= cmd_d;
        end
    end

    // valid is high for exactly the cycle after a launch
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_go;
        end
    end

endmodule

// ==== issue_xarith_port.sv ====
`timescale 1ns/1ps

module issue_xarith_port (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  issue_pkg::issue_bundle_t  i_bundle0,
    input  issue_pkg::issue_bundle_t  i_bundle1,
    input  logic                      i_go,
    input  logic                      i_sel1,
    output issue_pkg::xarith_cmd_t    o_cmd,
    output logic                      o_valid
);

    issue_pkg::issue_bundle_t bundle;
    issue_pkg::xarith_cmd_t   cmd_d;

    // operands come from whichever bundle is being sent to this unit
    assign bundle = i_sel1 ? i_bundle1 : i_bundle0;

    always_comb begin
        cmd_d.banksel = i_sel1;
        cmd_d.op2_sel = bundle.op2_sel;
        cmd_d.imm     = issue_pkg::sext_imm(bundle.imm);
        cmd_d.ctrl    = bundle.xarith;
        cmd_d.rd      = bundle.rd;
    end

    // the command only changes on a launch and is held otherwise
    always_ff @(posedge i_clk) begin
        if (i_go) begin
            o_cmd <= cmd_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_go;
        end
    end

endmodule

// ==== issue_pair_ctrl.sv ====
`timescale 1ns/1ps

module issue_pair_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  issue_pkg::issue_bundle_t  i_bundle0,
    input  issue_pkg::issue_bundle_t  i_bundle1,
    input  logic                      i_clear0,
    input  logic                      i_clear1,
    input  logic                      i_xarith_ready,
    input  logic                      i_xlogic_ready,
    output logic                      o_send0,
    output logic                      o_send1,
    output logic                      o_input_ready,
    output logic                      o_xarith_go,
    output logic                      o_xarith_sel1,
    output logic                      o_xlogic_go,
    output logic                      o_xlogic_sel1
);

    issue_pkg::pair_state_e state_q;
    issue_pkg::pair_state_e state_d;

    logic b0_xarith;
    logic b0_xlogic;
    logic b1_xarith;
    logic b1_xlogic;
    logic b0_unit_ready;
    logic b1_unit_ready;
    logic same_unit;
    logic same_rd;
    logic b1_after_b0;

    // pipeline decode, a code naming no unit leaves both flags low and the
    // bundle can never transmit
    assign b0_xarith = i_bundle0.pipeline == issue_pkg::PIPE_XARITH;
    assign b0_xlogic = i_bundle0.pipeline == issue_pkg::PIPE_XLOGIC;
    assign b1_xarith = i_bundle1.pipeline == issue_pkg::PIPE_XARITH;
    assign b1_xlogic = i_bundle1.pipeline == issue_pkg::PIPE_XLOGIC;

    assign b0_unit_ready = (b0_xarith && i_xarith_ready) || (b0_xlogic && i_xlogic_ready);
    assign b1_unit_ready = (b1_xarith && i_xarith_ready) || (b1_xlogic && i_xlogic_ready);

    // both bundles share a unit, so they cannot leave in the same cycle
    assign same_unit = (b0_xarith && b1_xarith) || (b0_xlogic && b1_xlogic);

    // in-pair WAW, only relevant while bundle 0 is still in this stage
    assign same_rd = i_bundle0.rd == i_bundle1.rd;

    assign o_send0 = i_valid && (state_q == issue_pkg::PAIR_BOTH)
                     && i_clear0 && b0_unit_ready;

    // bundle 1 may go once bundle 0 is gone, or alongside it when the two
    // do not collide on a unit or a destination
    assign b1_after_b0 = (state_q == issue_pkg::PAIR_SECOND)
                         || (o_send0 && !same_rd && !same_unit);

    assign o_send1 = i_valid && i_clear1 && b1_unit_ready && b1_after_b0;

    // the pair is consumed in the cycle the second bundle leaves
    assign o_input_ready = o_send1;

    // at most one bundle reaches a given unit per cycle
    assign o_xarith_go   = (o_send0 && b0_xarith) || (o_send1 && b1_xarith);
    assign o_xarith_sel1 = o_send1 && b1_xarith;
    assign o_xlogic_go   = (o_send0 && b0_xlogic) || (o_send1 && b1_xlogic);
    assign o_xlogic_sel1 = o_send1 && b1_xlogic;

    always_comb begin
        state_d = state_q;
        case (state_q)
            issue_pkg::PAIR_BOTH: begin
                if (o_send0 && !o_send1) begin
                    state_d = issue_pkg::PAIR_SECOND;
                end
            end
            issue_pkg::PAIR_SECOND: begin
                if (o_send1) begin
                    state_d = issue_pkg::PAIR_BOTH;
                end
            end
            default: begin
                state_d = issue_pkg::PAIR_BOTH;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= issue_pkg::PAIR_BOTH;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== issue_scoreboard.sv ====
`timescale 1ns/1ps

module issue_scoreboard (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  issue_pkg::issue_bundle_t  i_bundle0,
    input  issue_pkg::issue_bundle_t  i_bundle1,
    input  logic                      i_send0,
    input  logic                      i_send1,
    input  issue_pkg::reg_mask_t      i_retire0,
    input  issue_pkg::reg_mask_t      i_retire1,
    output logic                      o_clear0,
    output logic                      o_clear1
);

    // one bit per register that has an instruction in flight writing it
    issue_pkg::reg_mask_t reservation;
    issue_pkg::reg_mask_t bundle0_mask;
    issue_pkg::reg_mask_t bundle1_mask;
    issue_pkg::reg_mask_t reserve;
    issue_pkg::reg_mask_t retire;

    function automatic issue_pkg::reg_mask_t one_hot(input issue_pkg::reg_addr_t addr);
        return issue_pkg::reg_mask_t'(1) << addr;
    endfunction

    // every register the bundle touches, rs2 drops out when the immediate
    // takes its place as the second operand
    function automatic issue_pkg::reg_mask_t touch_mask(
        input issue_pkg::issue_bundle_t b
    );
        issue_pkg::reg_mask_t rs2_mask;
        rs2_mask = b.op2_sel ? '0 : one_hot(b.rs2);
        return one_hot(b.rs1) | rs2_mask | one_hot(b.rd);
    endfunction

    assign bundle0_mask = touch_mask(i_bundle0);
    assign bundle1_mask = touch_mask(i_bundle1);

    // a bundle is clear when none of its registers is reserved, which covers
    // RAW on the sources and WAW on the destination
    assign o_clear0 = (reservation & bundle0_mask) == '0;
    assign o_clear1 = (reservation & bundle1_mask) == '0;

    assign retire = i_retire0 | i_retire1;

    always_comb begin
        reserve = '0;
        if (i_send0) begin
            reserve = reserve | one_hot(i_bundle0.rd);
        end
        if (i_send1) begin
            reserve = reserve | one_hot(i_bundle1.rd);
        end
        reserve = reserve & ~issue_pkg::REG_ZERO_MASK;
    end

    // the reserve is applied after the retire so a new writer of the same
    // register keeps its bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reservation <= '0;
        end else begin
            reservation <= (reservation & ~retire) | reserve;
        end
    end

endmodule

// ==== issue_pkg.sv ====
package issue_pkg;

    // widths fixed by the RV64I instruction set
    localparam int REG_COUNT   = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMM_SHORT_W = 32;
    localparam int XLEN        = 64;
    localparam int PIPE_W      = 4;

    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [REG_COUNT-1:0]   reg_mask_t;
    typedef logic [IMM_SHORT_W-1:0] imm_short_t;
    typedef logic [XLEN-1:0]        imm_t;

    // x0 is hardwired to zero, so it never takes a reservation
    localparam reg_mask_t REG_ZERO_MASK = reg_mask_t'(1);

    // target execution unit of a bundle, any other code names no unit
    typedef enum logic [PIPE_W-1:0] {
        PIPE_XARITH = 4'd1,
        PIPE_XLOGIC = 4'd2
    } pipe_e;

    typedef struct packed {
        logic       word;
        logic       branch_invert;
        logic       branch_equal;
        logic       cmp_mode;
        // unsigned compare, the plain name is a reserved word
        logic       is_unsigned;
        logic       sub;
        logic [1:0] opsel;
    } xarith_ctrl_t;

    typedef struct packed {
        logic       word;
        logic [1:0] sll;
        logic       invert;
        logic [2:0] opsel;
    } xlogic_ctrl_t;

    // one decoded instruction as handed over by decode
    typedef struct packed {
        xlogic_ctrl_t xlogic;
        xarith_ctrl_t xarith;
        logic         op2_sel;
        pipe_e        pipeline;
        imm_short_t   imm;
        reg_addr_t    rd;
        reg_addr_t    rs2;
        reg_addr_t    rs1;
        logic         spare;
    } issue_bundle_t;

    // banksel picks (rs1, rs2) when low and (rs3, rs4) when high
    typedef struct packed {
        logic         banksel;
        logic         op2_sel;
        imm_t         imm;
        xarith_ctrl_t ctrl;
        reg_addr_t    rd;
    } xarith_cmd_t;

    typedef struct packed {
        logic         banksel;
        logic         op2_sel;
        imm_t         imm;
        xlogic_ctrl_t ctrl;
        reg_addr_t    rd;
    } xlogic_cmd_t;

    // PAIR_SECOND means bundle 0 already left and bundle 1 still waits
    typedef enum logic {
        PAIR_BOTH   = 1'b0,
        PAIR_SECOND = 1'b1
    } pair_state_e;

    // the bundle carries a short immediate, the units want a full XLEN operand
    function automatic imm_t sext_imm(input imm_short_t imm);
        return imm_t'(signed'(imm));
    endfunction

endpackage
